// ==== all.f ====
hw/rot_geom_pkg.sv
hw/rot_user_pkg.sv
hw/weight_bank.sv
hw/bank_writer.sv
hw/bank_reader.sv
hw/weight_rotator.sv
testbench/tb_weight_rotator.sv

// ==== hw/bank_reader.sv ====
// read FSM with nested down-counters, bank selection and the output stage
module bank_reader (
  input  logic                              i_aclk,
  input  logic                              i_rst,
  input  logic [1:0]                        i_bank_full,
  input  rot_geom_pkg::hdr_t                i_bank_hdr [2],
  input  logic [rot_geom_pkg::WORD_W-1:0]   i_bank_rd_data [2],
  input  logic                              i_m_ready,
  output logic [1:0]                        o_rd_en,
  output logic [1:0]                        o_rd_done,
  output logic                              o_m_valid,
  output logic [rot_geom_pkg::WORD_W-1:0]   o_m_data,
  output logic [rot_user_pkg::USER_W-1:0]   o_m_user,
  output logic                              o_m_last
);

  localparam logic [1:0] R_IDLE   = 2'd0;
  localparam logic [1:0] R_READ   = 2'd1;
  localparam logic [1:0] R_SWITCH = 2'd2;

  logic [1:0]                          state;
  logic                                rd_idx;
  logic                                rd_left;  // reads still to issue
  rot_geom_pkg::hdr_t                  hdr;
  logic [rot_geom_pkg::KH2_W:0]        cnt_kh;
  logic [rot_geom_pkg::KH2_W:0]        kh_top;
  logic [rot_geom_pkg::CIN_W-1:0]      cnt_cin;
  logic [rot_geom_pkg::COLS_W-1:0]     cnt_cols;
  logic [rot_geom_pkg::BLOCKS_W-1:0]   cnt_blocks;
  logic                                kh_zero;
  logic                                cin_zero;
  logic                                cols_zero;
  logic                                blocks_zero;
  logic                                tail;
  logic                                issue;
  logic                                m_hs;
  logic                                done;
  logic [rot_user_pkg::USER_W-1:0]     user_next;

  assign hdr    = i_bank_hdr[rd_idx];
  assign kh_top = {hdr.kh2, 1'b0};  // kh-1 = 2*kh2

  assign kh_zero     = (cnt_kh == '0);
  assign cin_zero    = (cnt_cin == '0);
  assign cols_zero   = (cnt_cols == '0);
  assign blocks_zero = (cnt_blocks == '0);
  assign tail        = kh_zero && cin_zero && cols_zero && blocks_zero;

  assign m_hs  = o_m_valid && i_m_ready;
  assign issue = (state == R_READ) && rd_left && (!o_m_valid || i_m_ready);
  assign done  = (state == R_READ) && m_hs && o_m_last;

  // the bank read register is the data half of the output stage
  assign o_m_data = i_bank_rd_data[rd_idx];

  always_comb begin
    o_rd_en   = 2'b00;
    o_rd_done = 2'b00;
    o_rd_en[rd_idx]   = issue;
    o_rd_done[rd_idx] = done;
  end

  always_comb begin
    user_next = '0;
    user_next[rot_user_pkg::U_KW2 +: rot_geom_pkg::KW2_W] = hdr.kw2;
    user_next[rot_user_pkg::U_W_FIRST] = (cnt_cols == hdr.cols_1) &&
                                         (cnt_cin == hdr.cin_1) && (cnt_kh == kh_top);
    user_next[rot_user_pkg::U_CIN_LAST]     = kh_zero && cin_zero;
    user_next[rot_user_pkg::U_COLS_1_K2]    = (cnt_cols == hdr.kw2);
    user_next[rot_user_pkg::U_TOP_BLOCK]    = (cnt_blocks == hdr.blocks_1);
    user_next[rot_user_pkg::U_BOTTOM_BLOCK] = blocks_zero;
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state     <= R_IDLE;
      rd_idx    <= 1'b0;
      rd_left   <= 1'b0;
      o_m_valid <= 1'b0;
    end else begin
      case (state)
        R_IDLE: begin
          if (i_bank_full[rd_idx]) begin
            state   <= R_READ;
            rd_left <= 1'b1;
          end
        end
        R_READ: begin
          if (issue && tail) rd_left <= 1'b0;  // final read of the tensor
          if (done) state <= R_SWITCH;
        end
        R_SWITCH: begin
          state  <= R_IDLE;
          rd_idx <= ~rd_idx;
        end
        default: state <= R_IDLE;
      endcase
      if (issue) begin
        o_m_valid <= 1'b1;
      end else if (m_hs) begin
        o_m_valid <= 1'b0;
      end
    end
  end

  // kh innermost, then cin, cols and blocks
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      cnt_kh     <= '0;
      cnt_cin    <= '0;
      cnt_cols   <= '0;
      cnt_blocks <= '0;
    end else if (state == R_IDLE) begin
      cnt_kh     <= kh_top;
      cnt_cin    <= hdr.cin_1;
      cnt_cols   <= hdr.cols_1;
      cnt_blocks <= hdr.blocks_1;
    end else if (issue) begin
      cnt_kh <= kh_zero ? kh_top : cnt_kh - 1'b1;
      if (kh_zero) begin
        cnt_cin <= cin_zero ? hdr.cin_1 : cnt_cin - 1'b1;
      end
      if (kh_zero && cin_zero) begin
        cnt_cols <= cols_zero ? hdr.cols_1 : cnt_cols - 1'b1;
      end
      if (kh_zero && cin_zero && cols_zero) begin
        cnt_blocks <= blocks_zero ? hdr.blocks_1 : cnt_blocks - 1'b1;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (issue) begin
      o_m_user <= user_next;
      o_m_last <= tail;
    end
  end

endmodule

// ==== hw/bank_writer.sv ====
// write FSM that takes the header and steers weight beats into the free bank
module bank_writer (
  input  logic                            i_aclk,
  input  logic                            i_rst,
  input  logic                            i_s_valid,
  input  rot_geom_pkg::in_word_t          i_s_data,
  input  logic                            i_s_last,
  input  logic [1:0]                      i_bank_free,
  output logic                            o_s_ready,
  output logic [1:0]                      o_hdr_en,
  output logic [1:0]                      o_wr_en,
  output logic [1:0]                      o_wr_done,
  output rot_geom_pkg::hdr_t              o_wr_hdr,
  output logic [rot_geom_pkg::WORD_W-1:0] o_wr_data
);

  localparam logic [1:0] W_IDLE   = 2'd0;
  localparam logic [1:0] W_HEADER = 2'd1;
  localparam logic [1:0] W_WRITE  = 2'd2;
  localparam logic [1:0] W_SWITCH = 2'd3;

  logic [1:0] state;
  logic       wr_idx;
  logic       s_hs;

  assign o_s_ready = (state == W_HEADER) || (state == W_WRITE);
  assign s_hs      = i_s_valid && o_s_ready;

  assign o_wr_hdr  = i_s_data.hdr;  // header view of the first beat
  assign o_wr_data = i_s_data.raw;

  always_comb begin
    o_hdr_en  = 2'b00;
    o_wr_en   = 2'b00;
    o_wr_done = 2'b00;
    o_hdr_en[wr_idx]  = s_hs && (state == W_HEADER);
    o_wr_en[wr_idx]   = s_hs && (state == W_WRITE);
    o_wr_done[wr_idx] = s_hs && (state == W_WRITE) && i_s_last;
  end

  // both banks are free at reset, so bank 0 can take a header at once
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state  <= W_HEADER;
      wr_idx <= 1'b0;
    end else begin
      case (state)
        W_IDLE:   if (i_bank_free[wr_idx]) state <= W_HEADER;
        W_HEADER: if (s_hs) state <= W_WRITE;
        W_WRITE:  if (s_hs && i_s_last) state <= W_SWITCH;
        W_SWITCH: begin
          state  <= W_IDLE;
          wr_idx <= ~wr_idx;  // next tensor goes to the other bank
        end
        default:  state <= W_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/rot_geom_pkg.sv ====
// tensor geometry field widths with the header struct and the input word union
package rot_geom_pkg;

  localparam int WORD_W   = 32;  // stream and bank word
  localparam int KW2_W    = 2;
  localparam int KH2_W    = 2;
  localparam int CIN_W    = 5;
  localparam int COLS_W   = 4;
  localparam int BLOCKS_W = 4;

  localparam int PAD_W = WORD_W - BLOCKS_W - COLS_W - CIN_W - KH2_W - KW2_W;

  // first beat of every tensor, msb field first
  typedef struct packed {
    logic [PAD_W-1:0]    pad;       // unused upper bits
    logic [BLOCKS_W-1:0] blocks_1;  // blocks minus one
    logic [COLS_W-1:0]   cols_1;    // columns minus one
    logic [CIN_W-1:0]    cin_1;     // input channels minus one
    logic [KH2_W-1:0]    kh2;       // kernel height is 2*kh2+1
    logic [KW2_W-1:0]    kw2;       // half kernel width
  } hdr_t;

  // one input word, seen as a header on the first beat and raw afterwards
  typedef union packed {
    hdr_t              hdr;
    logic [WORD_W-1:0] raw;
  } in_word_t;

endpackage

// ==== hw/rot_user_pkg.sv ====
// bit positions and width of the output side-band word
package rot_user_pkg;

  localparam int USER_W = 8;

  localparam int U_KW2          = 0;  // base of 2-bit kw2 field
  localparam int U_W_FIRST      = 2;  // first beat of a block
  localparam int U_CIN_LAST     = 3;  // last beat of a pass
  localparam int U_COLS_1_K2    = 4;  // remaining cols equal kw2
  localparam int U_TOP_BLOCK    = 5;
  localparam int U_BOTTOM_BLOCK = 6;

  // bit 7 stays zero

endpackage

// ==== hw/weight_bank.sv ====
// one ping-pong bank with memory, header registers, cyclic read pointer and flags
module weight_bank #(
  parameter int BANK_DEPTH = 256
) (
  input  logic                            i_aclk,
  input  logic                            i_rst,
  input  logic                            i_hdr_en,
  input  rot_geom_pkg::hdr_t              i_hdr,
  input  logic                            i_wr_en,
  input  logic [rot_geom_pkg::WORD_W-1:0] i_wr_data,
  input  logic                            i_wr_done,
  input  logic                            i_rd_en,
  input  logic                            i_rd_done,
  output logic                            o_free,
  output logic                            o_full,
  output rot_geom_pkg::hdr_t              o_hdr,
  output logic [rot_geom_pkg::WORD_W-1:0] o_rd_data
);

  localparam int ADDR_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

  logic [rot_geom_pkg::WORD_W-1:0] mem [BANK_DEPTH];
  logic [ADDR_W-1:0]               wr_ptr;
  logic [ADDR_W-1:0]               rd_ptr;
  logic [ADDR_W-1:0]               last_addr;  // address of last written word

  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_wr_data;
    end
    if (i_rd_en) begin
      o_rd_data <= mem[rd_ptr];  // registered read, held between reads
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_hdr_en) begin
      o_hdr <= i_hdr;
    end
    if (i_wr_en) begin
      last_addr <= wr_ptr;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_free <= 1'b1;
      o_full <= 1'b0;
    end else begin
      if (i_hdr_en) begin
        wr_ptr <= '0;
        o_full <= 1'b0;
        o_free <= 1'b0;  // claimed by the writer
      end else if (i_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_wr_done) begin
        o_full <= 1'b1;
      end
      if (i_rd_done) begin
        o_full <= 1'b0;
        o_free <= 1'b1;
        rd_ptr <= '0;
      end else if (i_rd_en) begin
        rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;  // wrap for next pass
      end
    end
  end

endmodule

// ==== hw/weight_rotator.sv ====
// top level with the writer, two ping-pong banks and the reader
module weight_rotator #(
  parameter int BANK_DEPTH = 256
) (
  input  logic                              i_aclk,
  input  logic                              i_rst,
  input  logic                              i_s_valid,
  output logic                              o_s_ready,
  input  logic [rot_geom_pkg::WORD_W-1:0]   i_s_data,
  input  logic                              i_s_last,
  output logic                              o_m_valid,
  input  logic                              i_m_ready,
  output logic [rot_geom_pkg::WORD_W-1:0]   o_m_data,
  output logic [rot_user_pkg::USER_W-1:0]   o_m_user,
  output logic                              o_m_last
);

  logic [1:0]                        wr_hdr_en;
  logic [1:0]                        wr_en;
  logic [1:0]                        wr_done;
  rot_geom_pkg::hdr_t                wr_hdr;
  logic [rot_geom_pkg::WORD_W-1:0]   wr_data;
  logic [1:0]                        bank_free;
  logic [1:0]                        rd_en;
  logic [1:0]                        rd_done;
  logic [1:0]                        bank_full;
  rot_geom_pkg::hdr_t                bank_hdr [2];
  logic [rot_geom_pkg::WORD_W-1:0]   bank_rd_data [2];

  bank_writer u_writer (
    .i_aclk      (i_aclk),
    .i_rst       (i_rst),
    .i_s_valid   (i_s_valid),
    .i_s_data    (i_s_data),
    .i_s_last    (i_s_last),
    .i_bank_free (bank_free),
    .o_s_ready   (o_s_ready),
    .o_hdr_en    (wr_hdr_en),
    .o_wr_en     (wr_en),
    .o_wr_done   (wr_done),
    .o_wr_hdr    (wr_hdr),
    .o_wr_data   (wr_data)
  );

  for (genvar g = 0; g < 2; g++) begin : g_bank
    weight_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .i_aclk    (i_aclk),
      .i_rst     (i_rst),
      .i_hdr_en  (wr_hdr_en[g]),
      .i_hdr     (wr_hdr),
      .i_wr_en   (wr_en[g]),
      .i_wr_data (wr_data),
      .i_wr_done (wr_done[g]),
      .i_rd_en   (rd_en[g]),
      .i_rd_done (rd_done[g]),
      .o_free    (bank_free[g]),
      .o_full    (bank_full[g]),
      .o_hdr     (bank_hdr[g]),
      .o_rd_data (bank_rd_data[g])
    );
  end

  bank_reader u_reader (
    .i_aclk         (i_aclk),
    .i_rst          (i_rst),
    .i_bank_full    (bank_full),
    .i_bank_hdr     (bank_hdr),
    .i_bank_rd_data (bank_rd_data),
    .i_m_ready      (i_m_ready),
    .o_rd_en        (rd_en),
    .o_rd_done      (rd_done),
    .o_m_valid      (o_m_valid),
    .o_m_data       (o_m_data),
    .o_m_user       (o_m_user),
    .o_m_last       (o_m_last)
  );

endmodule

// ==== testbench/tb_weight_rotator.sv ====
// testbench for weight_rotator with clock, reset, LFSR stimulus, reference model and checker
module tb_weight_rotator;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] LFSR_SEED  = 32'ha76b_9e50;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  localparam int          WAIT_LIMIT = 10000;  // cycles for any single wait
  localparam int          W          = rot_geom_pkg::WORD_W;

  logic                             i_aclk;
  logic                             i_rst;
  logic                             i_s_valid;
  logic                             o_s_ready;
  logic [W-1:0]                     i_s_data;
  logic                             i_s_last;
  logic                             o_m_valid;
  logic                             i_m_ready;
  logic [W-1:0]                     o_m_data;
  logic [rot_user_pkg::USER_W-1:0]  o_m_user;
  logic                             o_m_last;

  logic [31:0] lfsr = LFSR_SEED;
  logic [W-1:0] exp_data [$];
  logic [7:0]   exp_user [$];
  logic         exp_last [$];
  int           err_count = 0;
  int           beats_seen = 0;
  logic         hold_pending = 1'b0;  // beat was offered but not taken
  logic [W-1:0] held_data;
  logic [7:0]   held_user;
  logic         held_last;

  weight_rotator #(
    .BANK_DEPTH (256)
  ) u_dut (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user),
    .o_m_last  (o_m_last)
  );

  initial begin
    i_aclk = 1'b0;
    forever #20 i_aclk = ~i_aclk;
  end

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("=== FAIL ===");
    $finish;
  endtask

  // one clock, inputs change 2 ns after the edge
  task automatic step_cycle();
    @(posedge i_aclk);
    #2;
    i_m_ready = (rand_bits(2) != 2'd0);  // ready about 3 cycles in 4
  endtask

  task automatic check_idle_outputs();
    if (o_m_valid !== 1'b0) begin
      $display("[ERROR] %0t ns: o_m_valid is %b during or right after reset", $time, o_m_valid);
      err_count++;
    end
    if (o_s_ready !== 1'b1) begin
      $display("[ERROR] %0t ns: o_s_ready is %b during or right after reset", $time, o_s_ready);
      err_count++;
    end
  endtask

  task automatic send_beat(input logic [W-1:0] data, input logic last, input bit gaps);
    int idle;
    int waited;
    idle   = 0;
    waited = 0;
    while (gaps && idle < 4 && rand_bits(2) == 2'd0) begin
      idle++;
      step_cycle();
    end
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    while (!o_s_ready) begin  // ready depends only on writer state here
      if (waited >= WAIT_LIMIT) begin
        abort_run("input stream never became ready");
      end
      waited++;
      step_cycle();
    end
    step_cycle();  // transfer edge
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    i_s_data  = '0;
  endtask

  task automatic send_tensor(input int kw2, input int kh2, input int cin_1, input int cols_1,
                             input int blocks_1, input bit gaps, output int beats);
    logic [W-1:0] weights [$];
    logic [W-1:0] hdr_word;
    logic [7:0]   user;
    int           nw;
    nw       = (2 * kh2 + 1) * (cin_1 + 1);
    beats    = nw * (cols_1 + 1) * (blocks_1 + 1);
    hdr_word = {15'd0, 4'(blocks_1), 4'(cols_1), 5'(cin_1), 2'(kh2), 2'(kw2)};
    for (int w = 0; w < nw; w++) begin
      weights.push_back(rand_bits(32));
    end
    // expected output: every column pass of every block replays the weights
    for (int b = 0; b <= blocks_1; b++) begin
      for (int c = 0; c <= cols_1; c++) begin
        for (int w = 0; w < nw; w++) begin
          user = '0;
          user[rot_user_pkg::U_KW2 +: 2]          = 2'(kw2);
          user[rot_user_pkg::U_W_FIRST]          = (c == 0) && (w == 0);
          user[rot_user_pkg::U_CIN_LAST]         = (w == nw - 1);
          user[rot_user_pkg::U_COLS_1_K2]        = ((cols_1 - c) == kw2);
          user[rot_user_pkg::U_TOP_BLOCK]        = (b == 0);
          user[rot_user_pkg::U_BOTTOM_BLOCK]     = (b == blocks_1);
          exp_data.push_back(weights[w]);
          exp_user.push_back(user);
          exp_last.push_back((b == blocks_1) && (c == cols_1) && (w == nw - 1));
        end
      end
    end
    send_beat(hdr_word, 1'b0, gaps);
    for (int w = 0; w < nw; w++) begin
      send_beat(weights[w], (w == nw - 1), gaps);
    end
  endtask

  // zero_field picks kh2, cin_1, cols_1 or blocks_1 to force to zero
  task automatic send_random_tensor(input int zero_field, input bit gaps, output int beats);
    int kw2;
    int kh2;
    int cin_1;
    int cols_1;
    int blocks_1;
    kw2      = rand_bits(2);
    kh2      = rand_bits(2);
    cin_1    = rand_bits(3);
    cols_1   = rand_bits(3);
    blocks_1 = rand_bits(2);
    case (zero_field)
      1: kh2 = 0;
      2: cin_1 = 0;
      3: cols_1 = 0;
      4: blocks_1 = 0;
      default: ;
    endcase
    send_tensor(kw2, kh2, cin_1, cols_1, blocks_1, gaps, beats);
  endtask

  // done once every expected beat is out and the output has gone quiet
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0 || o_m_valid) begin
      if (waited >= 4 * WAIT_LIMIT) begin
        abort_run("output stream stopped before all expected beats arrived");
      end
      waited++;
      step_cycle();
    end
  endtask

  // sampled at the falling edge, where both sides are stable
  always @(negedge i_aclk) begin
    if (!i_rst) begin
      if (hold_pending && (o_m_valid !== 1'b1 || o_m_data !== held_data ||
                           o_m_user !== held_user || o_m_last !== held_last)) begin
        $display("[ERROR] %0t ns: output changed while stalled", $time);
        err_count++;
      end
      hold_pending = o_m_valid && !i_m_ready;
      held_data    = o_m_data;
      held_user    = o_m_user;
      held_last    = o_m_last;
      if (o_m_valid && i_m_ready) begin
        beats_seen++;
        if (exp_data.size() == 0) begin
          $display("%0t ns: output beat arrived with none expected", $time);
          err_count++;
        end else begin
          if (o_m_data !== exp_data[0]) begin
            $display("[ERROR] %0t ns: data 0x%08h, expected 0x%08h", $time, o_m_data, exp_data[0]);
            err_count++;
          end
          if (o_m_user !== exp_user[0]) begin
            $display("[ERROR] %0t ns: user 0x%02h, expected 0x%02h", $time, o_m_user, exp_user[0]);
            err_count++;
          end
          if (o_m_last !== exp_last[0]) begin
            $display("[ERROR] %0t ns: last %b, expected %b", $time, o_m_last, exp_last[0]);
            err_count++;
          end
          void'(exp_data.pop_front());
          void'(exp_user.pop_front());
          void'(exp_last.pop_front());
        end
      end
    end
  end

  initial begin
    int beats;
    int burst_total;
    int seen_before;
    i_rst     = 1'b1;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b0;
    repeat (8) begin
      step_cycle();
      check_idle_outputs();
    end
    i_rst = 1'b0;
    step_cycle();
    check_idle_outputs();  // first cycle out of reset

    send_tensor(1, 0, 0, 0, 0, 1'b1, beats);  // smallest tensor, a single beat
    wait_drain();
    send_random_tensor(0, 1'b1, beats);
    wait_drain();

    // six tensors with valid held high between beats
    burst_total = 0;
    seen_before = beats_seen;
    for (int t = 0; t < 6; t++) begin
      send_random_tensor(t, 1'b0, beats);
      burst_total += beats;
    end
    wait_drain();
    if (beats_seen - seen_before != burst_total) begin
      $display("[ERROR] %0t ns: burst gave %0d beats, expected %0d", $time,
               beats_seen - seen_before, burst_total);
      err_count++;
    end

    for (int t = 0; t < 3; t++) begin
      send_random_tensor(4 - t, 1'b1, beats);
    end
    wait_drain();
    repeat (20) begin
      step_cycle();  // catch any extra beats
    end

    $display("beats checked %0d, errors %0d, beats missing %0d", beats_seen, err_count,
             exp_data.size());
    if (err_count == 0 && exp_data.size() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
